// File: stackCpu_cfg.svh
/*
 * Widths, stack depth and fixed instruction-field positions of the
 * 8-bit stack processor. Included by the package and by every module
 * that sizes a signal from these values.
 */
`ifndef STACKCPU_CFG_SVH
`define STACKCPU_CFG_SVH

// --------------------------------------------------
// datapath and address sizes
// --------------------------------------------------
`define DATA_W      8   // data bus and stack entry width
`define ADDR_W      16  // program counter and bus address width
`define STACK_DEPTH 8   // operand stack entries
`define STACK_PTR_W 3   // indexes STACK_DEPTH entries and wraps

// --------------------------------------------------
// instruction byte layout
// --------------------------------------------------
`define OPCODE_W    6   // low opcode field
`define ALU_OP_W    4   // internal ALU task code
`define SKIP_C_BIT  7   // skip if carry clear
`define SKIP_Z_BIT  6   // skip if zero clear

`endif

// File: stackCpuPkg.sv
/*
 * Shared types of the stack processor: opcode, ALU task, stack operation
 * and sequencer state enums, plus the packed structs passed between the
 * sequencer, the operand stack and the ALU. Import with stackCpuPkg::*.
 */
`include "stackCpu_cfg.svh"

package stackCpuPkg;

    // low six bits of the instruction byte with pop forms on the odd codes
    typedef enum logic [`OPCODE_W-1:0] {
        opAdc    = 6'd0,  opAdcPop = 6'd1,
        opAdd    = 6'd2,  opAddPop = 6'd3,
        opAnd    = 6'd4,  opAndPop = 6'd5,
        opNeg    = 6'd10, opNot    = 6'd11,
        opOr     = 6'd12, opOrPop  = 6'd13,
        opSbb    = 6'd14, opSbbPop = 6'd15,
        opSub    = 6'd16, opSubPop = 6'd17,
        opXor    = 6'd18, opXorPop = 6'd19,
        opRcl    = 6'd20, opRcr    = 6'd21,
        opRol    = 6'd22, opRor    = 6'd23,
        opShl    = 6'd24, opShr    = 6'd25,
        opCc     = 6'd26, opCz     = 6'd27,
        opNc     = 6'd28, opNz     = 6'd29,
        opSc     = 6'd30, opSz     = 6'd31,
        opPop    = 6'd40,
        opJmpRel = 6'd44, opJmpAbs = 6'd45,
        opLdi    = 6'd56,
        opSt     = 6'd60, opStPop  = 6'd62
    } opcodeE;

    typedef enum logic [`ALU_OP_W-1:0] {
        aluPass, aluAdc, aluAdd, aluAnd, aluNeg, aluNot, aluOr, aluSbb,
        aluSub, aluXor, aluRcl, aluRcr, aluRol, aluRor, aluShl, aluShr
    } aluOpE;

    typedef enum logic [1:0] {
        stackNone, stackReplace, stackPush, stackPopReplace
    } stackOpE;

    typedef enum logic [2:0] {
        seqDecode, seqWriteBack, seqLdiData, seqJmpLo, seqJmpHi,
        seqStAddrLo, seqStAddrHi, seqStWrite
    } seqStateE;

    typedef struct packed {
        logic carry;
        logic zero;
    } flagsT;

    typedef struct packed {
        logic [`DATA_W-1:0] top;
        logic [`DATA_W-1:0] next;   // entry below top
    } stackTopT;

    typedef struct packed {
        aluOpE              op;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic               carryIn;
    } aluReqT;

    typedef struct packed {
        logic [`DATA_W-1:0] result;
        flagsT              flags;
    } aluRespT;

endpackage

// File: stackCpuStack.sv
/*
 * Eight-entry operand stack on a wrapping pointer. One operation per
 * cycle: replace the top, push a new top, or drop the top and overwrite
 * the entry below it. The top two entries are always visible.
 */
`timescale 1ns/100ps
`include "stackCpu_cfg.svh"

module stackCpuStack import stackCpuPkg::*; (
    input  logic               Clk,
    input  logic               rstN,
    input  stackOpE            op,
    input  logic [`DATA_W-1:0] wrData,
    output stackTopT           top
);

    logic [`DATA_W-1:0]     mem [`STACK_DEPTH];
    logic [`STACK_PTR_W-1:0] ptr;      // index of the current top
    logic [`STACK_PTR_W-1:0] ptrUp;
    logic [`STACK_PTR_W-1:0] ptrDn;

    assign ptrUp = ptr + 1'b1;         // wraps past the last entry
    assign ptrDn = ptr - 1'b1;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ptr <= '0;
            for (int i = 0; i < `STACK_DEPTH; i++) begin
                mem[i] <= '0;          // empty stack reads as zeros
            end
        end else begin
            case (op)
                stackReplace: begin
                    mem[ptr] <= wrData;
                end
                stackPush: begin
                    mem[ptrUp] <= wrData;
                    ptr        <= ptrUp;
                end
                stackPopReplace: begin
                    mem[ptrDn] <= wrData; // old next becomes new top
                    ptr        <= ptrDn;
                end
                default: ;
            endcase
        end
    end

    assign top.top  = mem[ptr];
    assign top.next = mem[ptrDn];

endmodule

// File: stackCpuAlu.sv
/*
 * Combinational 8-bit ALU. Takes the registered request from the
 * sequencer and returns the result with new carry and zero flags.
 * Two-operand tasks compute a op b where a is the entry below the top.
 */
`timescale 1ns/100ps
`include "stackCpu_cfg.svh"

module stackCpuAlu import stackCpuPkg::*; (
    input  aluReqT  req,
    output aluRespT resp
);

    logic [`DATA_W:0]   wide;      // one extra bit for carry or borrow
    logic [`DATA_W:0]   cinWide;
    logic [`DATA_W-1:0] res;
    logic               carry;

    assign cinWide = {{`DATA_W{1'b0}}, req.carryIn};

    always_comb begin
        wide  = '0;
        res   = req.a;
        carry = 1'b0;
        case (req.op)
            aluPass: begin
                carry = req.carryIn;   // flags are not committed for pass
            end
            // --------------------------------------------------
            // arithmetic
            // --------------------------------------------------
            aluAdc: begin
                wide  = {1'b0, req.a} + {1'b0, req.b} + cinWide;
                res   = wide[`DATA_W-1:0];
                carry = wide[`DATA_W];
            end
            aluAdd: begin
                wide  = {1'b0, req.a} + {1'b0, req.b};
                res   = wide[`DATA_W-1:0];
                carry = wide[`DATA_W];
            end
            aluSbb: begin
                wide  = {1'b0, req.a} - {1'b0, req.b} - cinWide;
                res   = wide[`DATA_W-1:0];
                carry = wide[`DATA_W]; // borrow
            end
            aluSub: begin
                wide  = {1'b0, req.a} - {1'b0, req.b};
                res   = wide[`DATA_W-1:0];
                carry = wide[`DATA_W];
            end
            aluNeg: res = '0 - req.a;
            // --------------------------------------------------
            // logic ops with carry cleared
            // --------------------------------------------------
            aluAnd: res = req.a & req.b;
            aluOr:  res = req.a | req.b;
            aluXor: res = req.a ^ req.b;
            aluNot: res = ~req.a;
            // --------------------------------------------------
            // shifts and rotates
            // --------------------------------------------------
            aluRcl: {carry, res} = {req.a, req.carryIn};  // 9-bit rotate left
            aluRcr: {res, carry} = {req.carryIn, req.a};  // 9-bit rotate right
            aluRol: begin
                res   = {req.a[`DATA_W-2:0], req.a[`DATA_W-1]};
                carry = req.a[`DATA_W-1];
            end
            aluRor: begin
                res   = {req.a[0], req.a[`DATA_W-1:1]};
                carry = req.a[0];
            end
            aluShl: {carry, res} = {req.a, 1'b0};
            aluShr: {res, carry} = {1'b0, req.a};
        endcase
    end

    assign resp.result      = res;
    assign resp.flags.carry = carry;
    assign resp.flags.zero  = (res == '0);

endmodule

// File: stackCpuSeq.sv
/*
 * Instruction sequencer. Fetches bytes at pc while progValid is high,
 * handles the carry/zero skip prefix, the flag instructions, jumps and
 * stores, and sets up ALU requests that are written back to the operand
 * stack one cycle after decode. Each state that reads prog waits for
 * progValid, holding pc meanwhile.
 */
`timescale 1ns/100ps
`include "stackCpu_cfg.svh"

module stackCpuSeq import stackCpuPkg::*; (
    input  logic               Clk,
    input  logic               rstN,
    input  logic [`DATA_W-1:0] prog,
    input  logic               progValid,
    output logic [`ADDR_W-1:0] pc,
    input  stackTopT           stackTop,
    output stackOpE            stackOp,
    output logic [`DATA_W-1:0] stackWrData,
    output aluReqT             aluReq,
    input  aluRespT            aluResp,
    output logic [`ADDR_W-1:0] busAddress,
    output logic [`DATA_W-1:0] busDataOut,
    output logic               busLatch
);

    seqStateE           state;
    flagsT              flags;
    stackOpE            wbOp;       // stack op applied in writeBack
    opcodeE             curOp;      // opcode kept for operand states
    logic [`DATA_W-1:0] addrLo;     // low address byte of jmp abs / st

    opcodeE             opcode;
    logic               skip;
    aluOpE              decAluOp;
    stackOpE            decWbOp;
    logic               decUseNext; // a operand from next instead of top
    logic [`ADDR_W-1:0] instLen;
    logic [`ADDR_W-1:0] pcInc;
    logic [`ADDR_W-1:0] pcSkip;
    logic [`ADDR_W-1:0] pcRel;

    assign opcode = opcodeE'(prog[`OPCODE_W-1:0]);
    assign skip   = (prog[`SKIP_C_BIT] && !flags.carry) ||
                    (prog[`SKIP_Z_BIT] && !flags.zero);
    assign pcInc  = pc + 1'b1;
    assign pcSkip = pc + instLen;
    // offset is relative to the opcode, one byte before the operand
    assign pcRel  = pc + {{(`ADDR_W-`DATA_W){prog[`DATA_W-1]}}, prog} - 1'b1;

    // --------------------------------------------------
    // opcode decode
    // --------------------------------------------------
    always_comb begin
        decAluOp = aluPass;
        case (opcode)
            opAdc, opAdcPop: decAluOp = aluAdc;
            opAdd, opAddPop: decAluOp = aluAdd;
            opAnd, opAndPop: decAluOp = aluAnd;
            opOr,  opOrPop:  decAluOp = aluOr;
            opSbb, opSbbPop: decAluOp = aluSbb;
            opSub, opSubPop: decAluOp = aluSub;
            opXor, opXorPop: decAluOp = aluXor;
            opNeg:           decAluOp = aluNeg;
            opNot:           decAluOp = aluNot;
            opRcl:           decAluOp = aluRcl;
            opRcr:           decAluOp = aluRcr;
            opRol:           decAluOp = aluRol;
            opRor:           decAluOp = aluRor;
            opShl:           decAluOp = aluShl;
            opShr:           decAluOp = aluShr;
            default: ;
        endcase
    end

    always_comb begin
        decWbOp    = stackNone;
        decUseNext = 1'b0;
        instLen    = `ADDR_W'(1);
        case (opcode)
            opAdc, opAdcPop, opAdd, opAddPop, opAnd, opAndPop, opOr, opOrPop,
            opSbb, opSbbPop, opSub, opSubPop, opXor, opXorPop: begin
                decUseNext = 1'b1;
                decWbOp    = prog[0] ? stackPopReplace : stackReplace;
            end
            opNeg, opNot, opRcl, opRcr, opRol, opRor, opShl, opShr: begin
                decWbOp = stackReplace;
            end
            opPop: begin
                decUseNext = 1'b1;
                decWbOp    = stackPopReplace;
            end
            opLdi: begin
                decWbOp = stackPush;
                instLen = `ADDR_W'(2);
            end
            opJmpRel: instLen = `ADDR_W'(2);
            opJmpAbs, opSt: instLen = `ADDR_W'(3);
            opStPop: begin
                decUseNext = 1'b1;
                decWbOp    = stackPopReplace;
                instLen    = `ADDR_W'(3);
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // control state, pc and flags
    // --------------------------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state    <= seqDecode;
            pc       <= '0;
            flags    <= '0;
            wbOp     <= stackNone;
            busLatch <= 1'b0;
        end else begin
            busLatch <= 1'b0;              // single-cycle strobe
            case (state)
                seqDecode: begin
                    if (progValid) begin
                        if (skip) begin
                            pc <= pcSkip;  // whole instruction stepped over
                        end else begin
                            pc   <= pcInc;
                            wbOp <= decWbOp;
                            case (opcode)
                                opCc: flags.carry <= 1'b0;
                                opCz: flags.zero  <= 1'b0;
                                opNc: flags.carry <= !flags.carry;
                                opNz: flags.zero  <= !flags.zero;
                                opSc: flags.carry <= 1'b1;
                                opSz: flags.zero  <= 1'b1;
                                opLdi: state <= seqLdiData;
                                opJmpRel, opJmpAbs: state <= seqJmpLo;
                                opSt, opStPop: state <= seqStAddrLo;
                                default: begin
                                    if (decWbOp != stackNone) begin
                                        state <= seqWriteBack;
                                    end
                                end
                            endcase
                        end
                    end
                end
                seqWriteBack: begin
                    if (aluReq.op != aluPass) begin
                        flags <= aluResp.flags;  // ALU instructions only
                    end
                    state <= seqDecode;
                end
                seqLdiData: begin
                    if (progValid) begin
                        pc    <= pcInc;
                        state <= seqWriteBack;
                    end
                end
                seqJmpLo: begin
                    if (progValid) begin
                        if (curOp == opJmpAbs) begin
                            pc    <= pcInc;
                            state <= seqJmpHi;
                        end else begin
                            pc    <= pcRel;
                            state <= seqDecode;
                        end
                    end
                end
                seqJmpHi: begin
                    if (progValid) begin
                        pc    <= {prog, addrLo};
                        state <= seqDecode;
                    end
                end
                seqStAddrLo: begin
                    if (progValid) begin
                        pc    <= pcInc;
                        state <= seqStAddrHi;
                    end
                end
                seqStAddrHi: begin
                    if (progValid) begin
                        pc       <= pcInc;
                        busLatch <= 1'b1;  // high for the stWrite cycle
                        state    <= seqStWrite;
                    end
                end
                seqStWrite: begin
                    state <= (wbOp != stackNone) ? seqWriteBack : seqDecode;
                end
                default: state <= seqDecode;
            endcase
        end
    end

    // --------------------------------------------------
    // operand and bus payload
    // --------------------------------------------------
    always_ff @(posedge Clk) begin
        case (state)
            seqDecode: begin
                if (progValid && !skip) begin
                    curOp          <= opcode;
                    aluReq.op      <= decAluOp;
                    aluReq.a       <= decUseNext ? stackTop.next : stackTop.top;
                    aluReq.b       <= stackTop.top;
                    aluReq.carryIn <= flags.carry;
                end
            end
            seqLdiData: begin
                if (progValid) begin
                    aluReq.a <= prog;      // immediate passes through the ALU
                end
            end
            seqJmpLo, seqStAddrLo: begin
                if (progValid) begin
                    addrLo <= prog;
                end
            end
            seqStAddrHi: begin
                if (progValid) begin
                    busAddress <= {prog, addrLo};
                    busDataOut <= stackTop.top;
                end
            end
            default: ;
        endcase
    end

    assign stackOp     = (state == seqWriteBack) ? wbOp : stackNone;
    assign stackWrData = aluResp.result;

endmodule

// File: stackCpu.sv
/*
 * Top level of the 8-bit stack processor. Program bytes come from an
 * external ROM addressed by pc and qualified by progValid. Stores leave
 * on busAddress/busDataOut during the single-cycle busLatch pulse.
 */
`timescale 1ns/100ps
`include "stackCpu_cfg.svh"

module stackCpu import stackCpuPkg::*; (
    input  logic               Clk,
    input  logic               rstN,
    output logic [`ADDR_W-1:0] pc,
    input  logic [`DATA_W-1:0] prog,
    input  logic               progValid,
    output logic [`ADDR_W-1:0] busAddress,
    output logic [`DATA_W-1:0] busDataOut,
    output logic               busLatch
);

    stackTopT           stackTop;     // shared by ALU operands and store data
    stackOpE            stackOp;
    logic [`DATA_W-1:0] stackWrData;
    aluReqT             aluReq;
    aluRespT            aluResp;

    stackCpuSeq uSeq (
        .Clk         (Clk),
        .rstN        (rstN),
        .prog        (prog),
        .progValid   (progValid),
        .pc          (pc),
        .stackTop    (stackTop),
        .stackOp     (stackOp),
        .stackWrData (stackWrData),
        .aluReq      (aluReq),
        .aluResp     (aluResp),
        .busAddress  (busAddress),
        .busDataOut  (busDataOut),
        .busLatch    (busLatch)
    );

    stackCpuStack uStack (
        .Clk    (Clk),
        .rstN   (rstN),
        .op     (stackOp),
        .wrData (stackWrData),
        .top    (stackTop)
    );

    stackCpuAlu uAlu (
        .req  (aluReq),
        .resp (aluResp)
    );

endmodule

// File: stackCpu_props.sv
/*
 * Concurrent checks on the stack processor ports, bound into every
 * stackCpu instance: single-cycle store strobe, quiet bus out of reset,
 * and a program counter that holds while the ROM stalls.
 */
`timescale 1ns/100ps
`include "stackCpu_cfg.svh"

module stackCpuProps (
    input logic               Clk,
    input logic               rstN,
    input logic [`ADDR_W-1:0] pc,
    input logic               progValid,
    input logic               busLatch
);

    latchOneCycle: assert property (@(posedge Clk) disable iff (!rstN)
        busLatch |=> !busLatch)
        else $error("busLatch high on two consecutive cycles");

    latchLowAfterReset: assert property (@(posedge Clk)
        $rose(rstN) |-> !busLatch)
        else $error("busLatch high right after reset");

    pcHoldWhileStalled: assert property (@(posedge Clk) disable iff (!rstN)
        !progValid |=> $stable(pc))
        else $error("pc moved while progValid was low");

endmodule

bind stackCpu stackCpuProps props (
    .Clk       (Clk),
    .rstN      (rstN),
    .pc        (pc),
    .progValid (progValid),
    .busLatch  (busLatch)
);

// File: stackCpuTb.sv
/*
 * Testbench for the 8-bit stack processor. Builds random programs from an
 * LFSR, serves them from a 64 KB ROM model with one cycle of latency and
 * random stalls, and checks every bus store against the store sequence
 * predicted by an instruction-level reference model.
 */
`timescale 1ns/100ps
`include "stackCpu_cfg.svh"

module stackCpuTb import stackCpuPkg::*; ();

    localparam int          numProgs  = 4;
    localparam int          numBlocks = 40;   // instruction groups per program
    localparam logic [31:0] lfsrSeed  = 32'h021d7801;
    localparam logic [5:0]  aluCodes [22] = '{
        opAdc, opAdcPop, opAdd, opAddPop, opAnd, opAndPop, opNeg, opNot,
        opOr, opOrPop, opSbb, opSbbPop, opSub, opSubPop, opXor, opXorPop,
        opRcl, opRcr, opRol, opRor, opShl, opShr
    };

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } storeT;

    logic               Clk;
    logic               rstN;
    logic [`ADDR_W-1:0] pc;
    logic [`DATA_W-1:0] prog;
    logic               progValid;
    logic [`ADDR_W-1:0] busAddress;
    logic [`DATA_W-1:0] busDataOut;
    logic               busLatch;

    logic [`DATA_W-1:0] rom [1 << `ADDR_W];
    storeT              expStores [$];
    logic [31:0]        genState;      // program generator LFSR
    logic [31:0]        stallState;    // progValid stall LFSR
    logic [`ADDR_W-1:0] wrPtr;
    logic [`ADDR_W-1:0] reqAddr;       // address of the byte now in flight
    longint             deadline;      // 0 while no program runs

    stackCpu dut (
        .Clk        (Clk),
        .rstN       (rstN),
        .pc         (pc),
        .prog       (prog),
        .progValid  (progValid),
        .busAddress (busAddress),
        .busDataOut (busDataOut),
        .busLatch   (busLatch)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // --------------------------------------------------
    // reporting
    // --------------------------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        if (got !== want) begin
            abortRun($sformatf("FAILED at time %0t ns: %s = 0x%0h, expected 0x%0h",
                               $time, name, got, want));
        end
    endtask

    // --------------------------------------------------
    // program generation
    // --------------------------------------------------
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [7:0] genBits(int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            genState = lfsrNext(genState);
            v        = {v[6:0], genState[0]};
        end
        return v;
    endfunction

    function automatic void emit(logic [7:0] b);
        rom[wrPtr] = b;
        wrPtr      = wrPtr + 16'd1;
    endfunction

    function automatic logic [7:0] pickPrefix();
        logic [7:0] r;
        r = genBits(3);                    // bit 2 enables a prefix picked by bits 1:0
        return r[2] ? {r[1:0], 6'b0} : 8'h00;
    endfunction

    function automatic void emitLdi();
        emit({2'b00, opLdi});
        emit(genBits(8));
    endfunction

    function automatic void emitStore(logic [7:0] opByte);
        emit(opByte);
        emit(genBits(8));
        emit(8'hF0);                       // data region F000-F0FF
    endfunction

    function automatic void fillRom();
        for (int i = 0; i < (1 << `ADDR_W); i++) begin
            rom[i] = i[15:8] ^ i[7:0];
        end
    endfunction

    function automatic logic [`ADDR_W-1:0] genProgram();
        logic [7:0]         kind;
        logic [7:0]         k;
        logic [7:0]         pre;
        logic [`ADDR_W-1:0] target;
        logic [`ADDR_W-1:0] endAddr;
        wrPtr = '0;
        repeat (3) emitLdi();              // seed the stack
        for (int i = 0; i < numBlocks; i++) begin
            kind = genBits(3);
            case (kind)
                8'd0, 8'd1, 8'd2: begin
                    if (genBits(1) == 8'd1) begin
                        pre = pickPrefix();
                        emit(pre | {2'b00, opLdi});   // a skip steps over the immediate too
                        emit(genBits(8));
                    end
                    k   = genBits(5);
                    pre = pickPrefix();
                    emit(pre | {2'b00, aluCodes[k % 22]});
                    emitStore({2'b00, opSt});
                end
                8'd3: begin
                    k   = genBits(3);
                    pre = pickPrefix();
                    emit(pre | ({2'b00, opCc} + (k % 6)));
                    pre = pickPrefix();
                    emitStore(pre | {2'b00, opSt});   // skip shows the flags
                end
                8'd4: begin
                    emitLdi();
                    pre = pickPrefix();
                    emitStore(pre | {2'b00, opStPop});
                end
                8'd5: begin
                    pre = pickPrefix();
                    emit(pre | {2'b00, opPop});
                    emitStore({2'b00, opSt});
                end
                8'd6: begin
                    k = genBits(2);        // garbage bytes jumped over
                    if (genBits(1) == 8'd1) begin
                        target = wrPtr + 16'd3 + {8'd0, k};
                        emit({2'b00, opJmpAbs});
                        emit(target[7:0]);
                        emit(target[15:8]);
                    end else begin
                        emit({2'b00, opJmpRel});
                        emit(8'd2 + k);
                    end
                    repeat (k) emit(genBits(8));
                end
                default: begin
                    // forward jump to a backward jump that lands on the st
                    emit({2'b00, opJmpRel});
                    emit(8'd7);
                    emitStore({2'b00, opSt});
                    emit({2'b00, opJmpRel});
                    emit(8'd4);
                    emit({2'b00, opJmpRel});
                    emit(8'hFB);           // back five bytes
                end
            endcase
        end
        endAddr = wrPtr;
        emit({2'b00, opJmpRel});           // park on a self-jump
        emit(8'd0);
        return endAddr;
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [`ADDR_W-1:0] instLength(logic [5:0] code);
        case (code)
            opLdi, opJmpRel:         return 16'd2;
            opJmpAbs, opSt, opStPop: return 16'd3;
            default:                 return 16'd1;
        endcase
    endfunction

    function automatic int refRun(logic [`ADDR_W-1:0] endAddr);
        logic [7:0]         stk [`STACK_DEPTH];
        logic [2:0]         sp;
        logic [`ADDR_W-1:0] p;
        logic [7:0]         ins;
        logic [7:0]         o1;
        logic [7:0]         o2;
        logic [7:0]         top;
        logic [7:0]         nxt;
        logic [8:0]         w;             // {carry, result}
        logic               cy;
        logic               zf;
        logic               isAlu;
        int                 n;
        for (int i = 0; i < `STACK_DEPTH; i++) begin
            stk[i] = '0;
        end
        sp = '0;
        p  = '0;
        cy = 1'b0;
        zf = 1'b0;
        n  = 0;
        while (p != endAddr && n < 5000) begin
            ins   = rom[p];
            o1    = rom[p + 16'd1];
            o2    = rom[p + 16'd2];
            top   = stk[sp];
            nxt   = stk[sp - 3'd1];
            w     = '0;
            isAlu = 1'b1;
            n++;
            if ((ins[7] && !cy) || (ins[6] && !zf)) begin
                p = p + instLength(ins[5:0]);   // prefix condition met
            end else begin
                case (ins[5:0])
                    opAdc, opAdcPop: w = {1'b0, nxt} + {1'b0, top} + {8'd0, cy};
                    opAdd, opAddPop: w = {1'b0, nxt} + {1'b0, top};
                    opSbb, opSbbPop: w = {1'b0, nxt} - {1'b0, top} - {8'd0, cy};
                    opSub, opSubPop: w = {1'b0, nxt} - {1'b0, top};
                    opAnd, opAndPop: w = {1'b0, nxt & top};
                    opOr, opOrPop:   w = {1'b0, nxt | top};
                    opXor, opXorPop: w = {1'b0, nxt ^ top};
                    opNeg:           w = {1'b0, 8'd0 - top};
                    opNot:           w = {1'b0, ~top};
                    opRcl:           w = {top, cy};
                    opRcr:           w = {top[0], cy, top[7:1]};
                    opRol:           w = {top, top[7]};
                    opRor:           w = {top[0], top[0], top[7:1]};
                    opShl:           w = {top, 1'b0};
                    opShr:           w = {top[0], 1'b0, top[7:1]};
                    default:         isAlu = 1'b0;
                endcase
                if (isAlu) begin
                    if (ins[5:0] inside {opAdcPop, opAddPop, opAndPop, opOrPop,
                                         opSbbPop, opSubPop, opXorPop}) begin
                        sp = sp - 3'd1;
                    end
                    stk[sp] = w[7:0];
                    cy      = w[8];
                    zf      = (w[7:0] == 8'd0);
                end
                case (ins[5:0])
                    opCc:  cy = 1'b0;
                    opCz:  zf = 1'b0;
                    opNc:  cy = !cy;
                    opNz:  zf = !zf;
                    opSc:  cy = 1'b1;
                    opSz:  zf = 1'b1;
                    opPop: sp = sp - 3'd1;
                    opLdi: begin
                        sp      = sp + 3'd1;
                        stk[sp] = o1;
                    end
                    opSt, opStPop: begin
                        expStores.push_back({o2, o1, top});
                        if (ins[5:0] == opStPop) begin
                            sp = sp - 3'd1;
                        end
                    end
                    default: ;
                endcase
                if (ins[5:0] == opJmpRel) begin
                    p = p + {{8{o1[7]}}, o1};   // from the opcode address
                end else if (ins[5:0] == opJmpAbs) begin
                    p = {o2, o1};
                end else begin
                    p = p + instLength(ins[5:0]);
                end
            end
        end
        return n;
    endfunction

    // --------------------------------------------------
    // ROM model, compare and watchdog
    // --------------------------------------------------
    initial begin
        forever begin
            @(posedge Clk);
            #10;
            stallState = lfsrNext(stallState);
            prog       = rom[reqAddr];
            progValid  = (reqAddr == pc) && !stallState[0];   // stale byte is invalid
            reqAddr    = pc;
        end
    end

    initial begin
        storeT want;
        forever begin
            @(negedge Clk);
            if (rstN && busLatch) begin
                if (expStores.size() == 0) begin
                    abortRun($sformatf("store to 0x%0h with data 0x%0h was not expected",
                                       busAddress, busDataOut));
                end else begin
                    want = expStores.pop_front();
                    checkEq("busAddress", {16'd0, busAddress}, {16'd0, want.addr});
                    checkEq("busDataOut", {24'd0, busDataOut}, {24'd0, want.data});
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge Clk);
            if (deadline != 0 && $time > deadline) begin
                abortRun("timeout: the program did not reach its final self-jump in time");
            end
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        logic [`ADDR_W-1:0] endAddr;
        int                 numInst;
        rstN       = 1'b0;
        prog       = '0;
        progValid  = 1'b0;
        genState   = lfsrSeed;
        stallState = lfsrSeed;
        reqAddr    = '0;
        deadline   = 0;
        for (int t = 0; t < numProgs; t++) begin
            if (t != 0) begin
                @(posedge Clk);
                #10;
                rstN = 1'b0;
            end
            deadline = 0;
            fillRom();
            endAddr = genProgram();
            expStores.delete();
            numInst = refRun(endAddr);
            $display("program %0d: %0d bytes, %0d instructions, %0d stores",
                     t, endAddr + 16'd2, numInst, expStores.size());
            repeat (2) @(posedge Clk);
            #10;
            rstN     = 1'b1;
            deadline = $time + longint'(numInst * 24 + 50) * 100;   // stalls at most double
            do begin
                @(negedge Clk);
            end while (expStores.size() != 0 || pc != endAddr);
            repeat (8) @(negedge Clk);     // idle on the self-jump
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: stackCpu.f
+incdir+.
stackCpuPkg.sv
stackCpuStack.sv
stackCpuAlu.sv
stackCpuSeq.sv
stackCpu.sv
stackCpu_props.sv
stackCpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the stack CPU testbench with Verilator and runs it.
# Exits non-zero unless the run reports a pass.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module stackCpuTb -f stackCpu.f -o stackCpuSim; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/stackCpuSim 2>&1)
simStatus=$?
echo "$simOut"

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "SIMULATION PASSED" <<< "$simOut"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
